// ==== hw/apb_regs_pkg.sv ====
package apb_regs_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_W   = 32;                         // APB address width
    localparam int DATA_W   = 32;                         // Register and bus data width
    localparam int NUM_REGS = 8;                          // Registers in the bank
    localparam int IRQ_W    = 32;                         // Interrupt event lines

    typedef logic [ADDR_W-1:0] addr_t;                    // Byte address on the bus
    typedef logic [DATA_W-1:0] data_t;                    // One register word
    typedef logic [2:0]        reg_idx_t;                 // Index into the bank

    // Whole bank contents, index 0 in the low word
    typedef data_t [NUM_REGS-1:0] reg_file_t;

    // ------------------------------
    // Register index names
    // ------------------------------
    localparam reg_idx_t IDX_REG0       = 3'd0;           // RW
    localparam reg_idx_t IDX_REG1       = 3'd1;           // RW
    localparam reg_idx_t IDX_STATUS     = 3'd2;           // Written by hardware only
    localparam reg_idx_t IDX_CONTROL    = 3'd3;           // Write only
    localparam reg_idx_t IDX_INT_ENABLE = 3'd4;           // RW
    localparam reg_idx_t IDX_INT_STATUS = 3'd5;           // Set by events, W1C
    localparam reg_idx_t IDX_W1S        = 3'd6;           // Write 1 to set
    localparam reg_idx_t IDX_TOGGLE     = 3'd7;           // Inverted by hardware event

    // ------------------------------
    // Address map
    // ------------------------------
    localparam addr_t ADDR_REG0       = 32'h0000_0000;
    localparam addr_t ADDR_REG1       = 32'h0000_0004;
    localparam addr_t ADDR_STATUS     = 32'h0000_0008;
    localparam addr_t ADDR_CONTROL    = 32'h0000_000C;
    localparam addr_t ADDR_INT_ENABLE = 32'h0000_0010;
    localparam addr_t ADDR_INT_STATUS = 32'h0000_0014;
    localparam addr_t ADDR_W1S        = 32'h0000_0018;
    localparam addr_t ADDR_TOGGLE     = 32'h0000_001C;    // Last mapped word

endpackage

// ==== hw/reg_access_if.sv ====
`timescale 1ns/1ps

// Decoded APB access, one set of levels per access phase
interface reg_access_if import apb_regs_pkg::*; ();

    logic     wr_stb;                                     // Legal SW write this phase
    logic     rd_stb;                                     // Legal SW read this phase
    reg_idx_t reg_idx;                                    // Addressed register
    data_t    wdata;                                      // Write data from PWDATA
    logic     err;                                        // Refused access

    // ------------------------------
    // Modports
    // ------------------------------
    modport decoder (
        output wr_stb,
        output rd_stb,
        output reg_idx,
        output wdata,
        output err
    );

    modport bank (
        input  wr_stb,
        input  reg_idx,
        input  wdata
    );

    modport resp (
        input  rd_stb,
        input  reg_idx,
        input  err
    );

endinterface

// ==== hw/apb_addr_decode.sv ====
`timescale 1ns/1ps

module apb_addr_decode import apb_regs_pkg::*; (
    input  logic  i_psel,                                 // Peripheral select
    input  logic  i_penable,                              // Second cycle of transfer
    input  logic  i_pwrite,                               // 1 write, 0 read
    input  addr_t i_paddr,                                // Byte address
    input  data_t i_pwdata,                               // Write data
    reg_access_if.decoder acc                             // Decoded access out
);

    logic     access;                                     // Access phase
    reg_idx_t idx;                                        // Index from address match
    logic     wr_ok;                                      // Address accepts SW writes
    logic     rd_ok;                                      // Address accepts SW reads

    assign access = i_psel && i_penable;

    // ------------------------------
    // Address map lookup
    // ------------------------------
    always_comb begin
        idx   = IDX_REG0;                                 // Don't care when unmapped
        wr_ok = 1'b0;
        rd_ok = 1'b0;
        case (i_paddr)
            ADDR_REG0: begin
                idx   = IDX_REG0;
                wr_ok = 1'b1;
                rd_ok = 1'b1;
            end
            ADDR_REG1: begin
                idx   = IDX_REG1;
                wr_ok = 1'b1;
                rd_ok = 1'b1;
            end
            ADDR_STATUS: begin
                idx   = IDX_STATUS;
                rd_ok = 1'b1;                             // HW owns the value
            end
            ADDR_CONTROL: begin
                idx   = IDX_CONTROL;
                wr_ok = 1'b1;                             // Reads refused
            end
            ADDR_INT_ENABLE: begin
                idx   = IDX_INT_ENABLE;
                wr_ok = 1'b1;
                rd_ok = 1'b1;
            end
            ADDR_INT_STATUS: begin
                idx   = IDX_INT_STATUS;
                wr_ok = 1'b1;                             // W1C
                rd_ok = 1'b1;
            end
            ADDR_W1S: begin
                idx   = IDX_W1S;
                wr_ok = 1'b1;
                rd_ok = 1'b1;
            end
            ADDR_TOGGLE: begin
                idx   = IDX_TOGGLE;
                rd_ok = 1'b1;                             // HW event only
            end
            default: ;                                    // Unmapped, both refused
        endcase
    end

    // ------------------------------
    // Strobes and error
    // ------------------------------
    assign acc.reg_idx = idx;
    assign acc.wdata   = i_pwdata;
    assign acc.wr_stb  = access && i_pwrite && wr_ok;
    assign acc.rd_stb  = access && !i_pwrite && rd_ok;
    assign acc.err     = access && !(i_pwrite ? wr_ok : rd_ok);

    // Only inside an access phase, and at most one outcome per phase
    always_comb begin
        a_one_outcome : assert final (
            $onehot0({acc.wr_stb, acc.rd_stb, acc.err}) &&
            (access || !(acc.wr_stb || acc.rd_stb || acc.err))
        );
    end

endmodule

// ==== hw/apb_reg_bank.sv ====
`timescale 1ns/1ps

module apb_reg_bank import apb_regs_pkg::*; (
    input  logic             i_pclk,                      // APB clock
    input  logic             i_presetn,                   // Async reset, active low
    reg_access_if.bank       acc,                         // Decoded SW write
    input  logic             i_status_hw_en,              // Load STATUS this edge
    input  data_t            i_status_hw,                 // New STATUS value
    input  logic             i_toggle_event,              // Invert TOGGLE this edge
    input  logic [IRQ_W-1:0] i_irq_event,                 // Sets INT_STATUS bits
    output reg_file_t        o_regs                       // Bank to result stage
);

    data_t reg0_q;
    data_t reg1_q;
    data_t status_q;
    data_t control_q;
    data_t int_enable_q;
    data_t int_status_q;
    data_t w1s_q;
    data_t toggle_q;

    // ------------------------------
    // Per-register write enables
    // ------------------------------
    logic  wr_reg0;
    logic  wr_reg1;
    logic  wr_control;
    logic  wr_int_enable;
    logic  wr_int_status;
    logic  wr_w1s;
    data_t w1c_mask;                                      // Bits SW clears in INT_STATUS

    assign wr_reg0       = acc.wr_stb && (acc.reg_idx == IDX_REG0);
    assign wr_reg1       = acc.wr_stb && (acc.reg_idx == IDX_REG1);
    assign wr_control    = acc.wr_stb && (acc.reg_idx == IDX_CONTROL);
    assign wr_int_enable = acc.wr_stb && (acc.reg_idx == IDX_INT_ENABLE);
    assign wr_int_status = acc.wr_stb && (acc.reg_idx == IDX_INT_STATUS);
    assign wr_w1s        = acc.wr_stb && (acc.reg_idx == IDX_W1S);
    assign w1c_mask      = wr_int_status ? acc.wdata : '0;

    // ------------------------------
    // Software registers
    // ------------------------------
    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn) begin
            reg0_q       <= '0;
            reg1_q       <= '0;
            control_q    <= '0;
            int_enable_q <= '0;
        end else begin
            if (wr_reg0)
                reg0_q <= acc.wdata;                      // Plain load
            if (wr_reg1)
                reg1_q <= acc.wdata;
            if (wr_control)
                control_q <= acc.wdata;                   // Seen by HW only
            if (wr_int_enable)
                int_enable_q <= acc.wdata;
        end
    end

    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn)
            w1s_q <= '0;
        else if (wr_w1s)
            w1s_q <= w1s_q | acc.wdata;                   // Ones accumulate
    end

    // ------------------------------
    // Hardware updated registers
    // ------------------------------
    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn)
            status_q <= '0;
        else if (i_status_hw_en)
            status_q <= i_status_hw;
    end

    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn)
            toggle_q <= '0;
        else if (i_toggle_event)
            toggle_q <= ~toggle_q;                        // Whole word flips
    end

    // Event OR applied after the clear, so an event beats W1C on the same bit
    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn)
            int_status_q <= '0;
        else
            int_status_q <= (int_status_q & ~w1c_mask) | i_irq_event;
    end

    // ------------------------------
    // Bank out
    // ------------------------------
    assign o_regs[IDX_REG0]       = reg0_q;
    assign o_regs[IDX_REG1]       = reg1_q;
    assign o_regs[IDX_STATUS]     = status_q;
    assign o_regs[IDX_CONTROL]    = control_q;
    assign o_regs[IDX_INT_ENABLE] = int_enable_q;
    assign o_regs[IDX_INT_STATUS] = int_status_q;
    assign o_regs[IDX_W1S]        = w1s_q;
    assign o_regs[IDX_TOGGLE]     = toggle_q;

    // W1S only gains bits until the next reset
    a_w1s_sticky : assert property (
        @(posedge i_pclk) disable iff (!i_presetn)
        (($past(w1s_q) & ~w1s_q) == '0)
    );

    // STATUS follows the HW load enable of the previous cycle
    a_status_hw_only : assert property (
        @(posedge i_pclk) disable iff (!i_presetn)
        (status_q != $past(status_q)) |-> $past(i_status_hw_en)
    );

endmodule

// ==== hw/apb_read_resp.sv ====
`timescale 1ns/1ps

module apb_read_resp import apb_regs_pkg::*; (
    input  logic       i_pclk,                            // APB clock
    input  logic       i_presetn,                         // Async reset, active low
    reg_access_if.resp acc,                               // Decoded read and error
    input  reg_file_t  i_regs,                            // Bank contents
    output data_t      o_prdata,                          // Read data
    output logic       o_pready,                          // Always ready
    output logic       o_pslverr,                         // Refused access
    output logic       o_irq                              // Registered IRQ request
);

    logic  irq_q;
    logic  irq_pending;                                   // Any enabled pending bit
    data_t int_status;
    data_t int_enable;

    // ------------------------------
    // Read data and response
    // ------------------------------
    assign o_prdata  = acc.rd_stb ? i_regs[acc.reg_idx] : '0;   // Zero when idle
    assign o_pslverr = acc.err;
    assign o_pready  = 1'b1;                              // No wait states

    // ------------------------------
    // Interrupt request
    // ------------------------------
    assign int_status  = i_regs[IDX_INT_STATUS];
    assign int_enable  = i_regs[IDX_INT_ENABLE];
    assign irq_pending = |(int_status & int_enable);

    always_ff @(posedge i_pclk or negedge i_presetn) begin
        if (!i_presetn)
            irq_q <= 1'b0;
        else
            irq_q <= irq_pending;                         // One edge behind the bank
    end

    assign o_irq = irq_q;

    // Bus stays quiet outside a legal read
    a_prdata_idle_zero : assert property (
        @(posedge i_pclk) disable iff (!i_presetn)
        !acc.rd_stb |-> (o_prdata == '0)
    );

endmodule

// ==== hw/apb_regfile_top.sv ====
`timescale 1ns/1ps

module apb_regfile_top import apb_regs_pkg::*; (
    // ------------------------------
    // APB
    // ------------------------------
    input  logic             i_pclk,                      // APB clock
    input  logic             i_presetn,                   // Async reset, active low
    input  logic             i_psel,
    input  logic             i_penable,
    input  logic             i_pwrite,
    input  addr_t            i_paddr,
    input  data_t            i_pwdata,
    output data_t            o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    // ------------------------------
    // Hardware side
    // ------------------------------
    input  logic             i_status_hw_en,              // STATUS load enable
    input  data_t            i_status_hw,                 // STATUS load value
    input  logic             i_toggle_event,              // TOGGLE invert pulse
    input  logic [IRQ_W-1:0] i_irq_event,                 // INT_STATUS set lines
    output logic             o_irq                        // Interrupt request
);

    reg_access_if u_acc ();                               // Decode to bank and resp
    reg_file_t    regs;                                   // Bank contents

    // Decode stage
    apb_addr_decode u_decode (
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .acc       (u_acc.decoder)
    );

    // Execute stage
    apb_reg_bank u_bank (
        .i_pclk         (i_pclk),
        .i_presetn      (i_presetn),
        .acc            (u_acc.bank),
        .i_status_hw_en (i_status_hw_en),
        .i_status_hw    (i_status_hw),
        .i_toggle_event (i_toggle_event),
        .i_irq_event    (i_irq_event),
        .o_regs         (regs)
    );

    // Result stage
    apb_read_resp u_resp (
        .i_pclk    (i_pclk),
        .i_presetn (i_presetn),
        .acc       (u_acc.resp),
        .i_regs    (regs),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_irq     (o_irq)
    );

endmodule

// ==== verif/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, address, write or pulse data, expected read data, expected PSLVERR
// Pulse rows use the data column as the STATUS value or the IRQ event lines

typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_STATUS, OP_TOGGLE,
    OP_IRQ, OP_IRQ_HIGH, OP_IRQ_LOW, OP_IRQ_QUIET
} op_e;

typedef struct packed {
    op_e   op;                                            // What the row does
    addr_t addr;                                          // Bus address
    data_t data;                                          // Write or pulse data
    data_t exp_data;                                      // Expected PRDATA
    logic  exp_err;                                       // Expected PSLVERR
} vec_t;

localparam int NUM_VECS = 44;

localparam vec_t VECS [NUM_VECS] = '{
    '{OP_READ,      ADDR_REG0,       32'h0,         32'h0,         1'b0},   // Reset values
    '{OP_READ,      ADDR_REG1,       32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_STATUS,     32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_INT_ENABLE, 32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_INT_STATUS, 32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_W1S,        32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_TOGGLE,     32'h0,         32'h0,         1'b0},
    '{OP_WRITE,     ADDR_REG0,       32'hA5A5_0001, 32'h0,         1'b0},   // RW readback
    '{OP_READ,      ADDR_REG0,       32'h0,         32'hA5A5_0001, 1'b0},
    '{OP_WRITE,     ADDR_REG1,       32'h1234_5678, 32'h0,         1'b0},
    '{OP_READ,      ADDR_REG1,       32'h0,         32'h1234_5678, 1'b0},
    '{OP_WRITE,     ADDR_INT_ENABLE, 32'h0000_00F0, 32'h0,         1'b0},
    '{OP_READ,      ADDR_INT_ENABLE, 32'h0,         32'h0000_00F0, 1'b0},
    '{OP_WRITE,     ADDR_CONTROL,    32'hDEAD_BEEF, 32'h0,         1'b0},   // Write only
    '{OP_READ,      ADDR_CONTROL,    32'h0,         32'h0,         1'b1},
    '{OP_WRITE,     ADDR_STATUS,     32'h1111_1111, 32'h0,         1'b1},   // HW owned
    '{OP_READ,      ADDR_STATUS,     32'h0,         32'h0,         1'b0},
    '{OP_WRITE,     ADDR_TOGGLE,     32'hFFFF_FFFF, 32'h0,         1'b1},
    '{OP_READ,      ADDR_TOGGLE,     32'h0,         32'h0,         1'b0},
    '{OP_WRITE,     32'h0000_0020,   32'h5555_5555, 32'h0,         1'b1},   // Unmapped
    '{OP_READ,      32'h0000_0020,   32'h0,         32'h0,         1'b1},
    '{OP_WRITE,     32'h0000_0002,   32'h0BAD_0BAD, 32'h0,         1'b1},   // Unaligned
    '{OP_READ,      32'h0000_0002,   32'h0,         32'h0,         1'b1},
    '{OP_READ,      ADDR_REG0,       32'h0,         32'hA5A5_0001, 1'b0},   // No alias
    '{OP_WRITE,     ADDR_W1S,        32'h0000_000F, 32'h0,         1'b0},   // Set by 1
    '{OP_WRITE,     ADDR_W1S,        32'h0000_0F00, 32'h0,         1'b0},
    '{OP_READ,      ADDR_W1S,        32'h0,         32'h0000_0F0F, 1'b0},
    '{OP_STATUS,    32'h0,           32'hCAFE_0042, 32'h0,         1'b0},   // HW load
    '{OP_READ,      ADDR_STATUS,     32'h0,         32'hCAFE_0042, 1'b0},
    '{OP_TOGGLE,    32'h0,           32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_TOGGLE,     32'h0,         32'hFFFF_FFFF, 1'b0},
    '{OP_TOGGLE,    32'h0,           32'h0,         32'h0,         1'b0},
    '{OP_READ,      ADDR_TOGGLE,     32'h0,         32'h0,         1'b0},
    '{OP_IRQ,       32'h0,           32'h0000_0003, 32'h0,         1'b0},   // Not enabled
    '{OP_READ,      ADDR_INT_STATUS, 32'h0,         32'h0000_0003, 1'b0},
    '{OP_IRQ_QUIET, 32'h0,           32'h0,         32'h0,         1'b0},
    '{OP_IRQ,       32'h0,           32'h0000_0030, 32'h0,         1'b0},   // Enabled bits
    '{OP_IRQ_HIGH,  32'h0,           32'h0,         32'h0,         1'b0},
    '{OP_WRITE,     ADDR_INT_STATUS, 32'h0000_0010, 32'h0,         1'b0},   // W1C bit 4
    '{OP_READ,      ADDR_INT_STATUS, 32'h0,         32'h0000_0023, 1'b0},
    '{OP_WRITE,     ADDR_INT_STATUS, 32'h0000_0020, 32'h0,         1'b0},   // Last enabled
    '{OP_IRQ_LOW,   32'h0,           32'h0,         32'h0,         1'b0},
    '{OP_WRITE,     ADDR_INT_STATUS, 32'h0000_0003, 32'h0,         1'b0},
    '{OP_READ,      ADDR_INT_STATUS, 32'h0,         32'h0,         1'b0}
};

`endif

// ==== verif/tb_apb_regfile.sv ====
`timescale 1ns/1ps

module tb_apb_regfile import apb_regs_pkg::*; ();

    localparam int        HALF_PERIOD  = 20;              // 40 ns clock
    localparam int        RESET_CYCLES = 8;
    localparam int        IRQ_TIMEOUT  = 10;              // Cycles to wait on o_irq
    localparam int        BUS_TIMEOUT  = 10;              // Cycles to wait on PREADY
    localparam int        RAND_ROUNDS  = 24;
    localparam bit [31:0] RAND_SEED    = 32'h9d21;

    `include "tb_vectors.svh"

    logic  pclk;
    logic  presetn;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;
    logic  status_hw_en;
    data_t status_hw;
    logic  toggle_event;
    data_t irq_event;                                     // One line per INT_STATUS bit
    logic  irq;

    data_t m_reg0;                                        // Model of the SW written regs
    data_t m_reg1;
    data_t m_w1s;

    apb_regfile_top i_dut (
        .i_pclk         (pclk),
        .i_presetn      (presetn),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr),
        .i_status_hw_en (status_hw_en),
        .i_status_hw    (status_hw),
        .i_toggle_event (toggle_event),
        .i_irq_event    (irq_event),
        .o_irq          (irq)
    );

    initial begin
        pclk = 1'b0;
        forever #HALF_PERIOD pclk = ~pclk;
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------
    // Bus and hardware drivers
    // ------------------------------
    task automatic access_phase(output data_t rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);                                  // Mid access phase
        while (pready !== 1'b1) begin
            if (cycles == BUS_TIMEOUT)
                abort_run("APB transfer never completed");
            cycles++;
            @(negedge pclk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge pclk);                                  // Edge that ends the transfer
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data,
                             output data_t rdata, output logic err);
        @(posedge pclk);
        psel   <= 1'b1;                                   // Setup phase
        pwrite <= 1'b1;
        paddr  <= addr;
        pwdata <= data;
        access_phase(rdata, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
        @(posedge pclk);
        psel   <= 1'b1;
        pwrite <= 1'b0;
        paddr  <= addr;
        access_phase(rdata, err);
    endtask

    task automatic pulse_hw(input op_e op, input data_t data);
        @(posedge pclk);
        case (op)
            OP_STATUS: begin
                status_hw_en <= 1'b1;
                status_hw    <= data;
            end
            OP_TOGGLE: toggle_event <= 1'b1;
            default:   irq_event    <= data;              // IRQ event lines
        endcase
        @(posedge pclk);                                  // High for exactly one edge
        status_hw_en <= 1'b0;
        toggle_event <= 1'b0;
        irq_event    <= '0;
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        @(negedge pclk);
        while (irq !== level) begin
            if (cycles == IRQ_TIMEOUT)
                abort_run(level ? "interrupt never asserted" : "interrupt never dropped");
            cycles++;
            @(negedge pclk);
        end
    endtask

    task automatic irq_quiet(input int row);
        repeat (IRQ_TIMEOUT) begin
            @(negedge pclk);
            check($sformatf("row %0d irq stays low", row), '0, 32'(irq));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_write(input addr_t addr, input data_t data);
        case (addr)
            ADDR_REG0: m_reg0 = data;
            ADDR_REG1: m_reg1 = data;
            ADDR_W1S:  m_w1s  = m_w1s | data;             // Ones only accumulate
            default: ;
        endcase
    endtask

    function automatic data_t model_read(input addr_t addr);
        case (addr)
            ADDR_REG0: return m_reg0;
            ADDR_REG1: return m_reg1;
            default:   return m_w1s;
        endcase
    endfunction

    function automatic bit [31:0] xorshift(input bit [31:0] x);
        bit [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        data_t     rdata;
        logic      err;
        vec_t      v;
        bit [31:0] rnd;
        addr_t     addr;
        psel         <= 1'b0;
        penable      <= 1'b0;
        pwrite       <= 1'b0;
        paddr        <= '0;
        pwdata       <= '0;
        status_hw_en <= 1'b0;
        status_hw    <= '0;
        toggle_event <= 1'b0;
        irq_event    <= '0;
        presetn      <= 1'b0;
        m_reg0 = '0;
        m_reg1 = '0;
        m_w1s  = '0;
        repeat (RESET_CYCLES) @(posedge pclk);
        presetn <= 1'b1;
        @(negedge pclk);
        check("reset irq", '0, 32'(irq));
        check("reset pslverr", '0, 32'(pslverr));

        for (int i = 0; i < NUM_VECS; i++) begin
            v = VECS[i];
            case (v.op)
                OP_WRITE: begin
                    apb_write(v.addr, v.data, rdata, err);
                    check($sformatf("row %0d write error", i), 32'(v.exp_err), 32'(err));
                    if (!v.exp_err)
                        model_write(v.addr, v.data);
                end
                OP_READ: begin
                    apb_read(v.addr, rdata, err);
                    check($sformatf("row %0d read data", i), v.exp_data, rdata);
                    check($sformatf("row %0d read error", i), 32'(v.exp_err), 32'(err));
                end
                OP_IRQ_HIGH:  wait_irq(1'b1);
                OP_IRQ_LOW:   wait_irq(1'b0);
                OP_IRQ_QUIET: irq_quiet(i);
                default:      pulse_hw(v.op, v.data);     // STATUS, TOGGLE or IRQ pulse
            endcase
        end

        // Random data on the SW writable words
        rnd = RAND_SEED;
        for (int n = 0; n < RAND_ROUNDS; n++) begin
            rnd = xorshift(rnd);
            case (rnd % 3)
                0:       addr = ADDR_REG0;
                1:       addr = ADDR_REG1;
                default: addr = ADDR_W1S;
            endcase
            rnd = xorshift(rnd);
            apb_write(addr, rnd, rdata, err);
            check($sformatf("random %0d write error", n), '0, 32'(err));
            model_write(addr, rnd);
            apb_read(addr, rdata, err);
            check($sformatf("random %0d read %h", n, addr), model_read(addr), rdata);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verif
hw/apb_regs_pkg.sv
hw/reg_access_if.sv
hw/apb_addr_decode.sv
hw/apb_reg_bank.sv
hw/apb_read_resp.sv
hw/apb_regfile_top.sv
verif/tb_apb_regfile.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_apb_regfile
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulator printed the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)
